// ==== src/rv_isa_pkg.sv ====
// Integer ISA types
`default_nettype none

package rv_isa_pkg;

  // Data word and register index of the RV32 integer core
  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;

  // Tracking id carried from the front end to commit
  typedef logic [7:0]  id_t;

  // Back-end opcodes, 3-bit encoding
  typedef enum logic [2:0] {
    OP_NOP     = 3'd0,
    OP_ADD     = 3'd1,
    OP_SUB     = 3'd2,
    OP_AND     = 3'd3,
    OP_XOR     = 3'd4,
    OP_SLL     = 3'd5,
    OP_MUL     = 3'd6,
    // Commits with the exception flag and flushes the back end
    OP_ILLEGAL = 3'd7
  } opcode_t;

  // Instruction as it enters the back end, 80 bits
  typedef struct packed {
    opcode_t  op;
    reg_idx_t rd;
    // Operand values, already read from the register file
    word_t    a;
    word_t    b;
    id_t      id;
  } instr_t;

endpackage

`default_nettype wire

// ==== src/cb_pkg.sv ====
// Completion buffer transport types
`default_nettype none

package cb_pkg;

  // Buffer slot tag, low bits select the entry
  typedef logic [7:0] tag_t;

  // Dispatch to lane
  typedef struct packed {
    logic                valid;
    rv_isa_pkg::instr_t  instr;
    tag_t                tag;
  } issue_t;

  // Lane to completion buffer, one-cycle ready pulse
  typedef struct packed {
    logic                 ready;
    tag_t                 tag;
    rv_isa_pkg::word_t    data;
    rv_isa_pkg::reg_idx_t rd;
    logic                 wen;
    logic                 exception;
    rv_isa_pkg::id_t      id;
  } result_t;

  // In-order commit port of the back end
  typedef struct packed {
    logic                 valid;
    rv_isa_pkg::id_t      id;
    rv_isa_pkg::reg_idx_t rd;
    rv_isa_pkg::word_t    data;
    logic                 wen;
    logic                 exception;
  } commit_t;

  // Lane FSM
  typedef enum logic {
    LANE_IDLE = 1'b0,
    // Iterative multiply in progress
    LANE_MUL  = 1'b1
  } lane_state_t;

endpackage

`default_nettype wire

// ==== src/dispatch_unit.sv ====
// Instruction dispatch
`default_nettype none
`timescale 1ns/1ns

module dispatch_unit #(
  parameter int NUM_ENTRY = 8,
  parameter int NUM_LANES = 3
) (
  input  logic                         CLK,
  input  logic                         nRST,
  input  rv_isa_pkg::instr_t           in_instr,
  input  logic                         in_valid,
  output logic                         in_ready,
  input  logic [$clog2(NUM_ENTRY)-1:0] tail,
  input  logic                         full,
  input  logic                         flush,
  input  logic [NUM_LANES-1:0]         busy,
  output logic                         alloc,
  output cb_pkg::issue_t               issue [NUM_LANES]
);

  // Goes high on the first edge after reset release
  logic                 run_q;
  logic [NUM_LANES-1:0] idle;
  // One-hot pick of the lowest idle lane
  logic [NUM_LANES-1:0] grant;
  logic [NUM_LANES-1:0] issue_vld;
  // Issue payload, shared by all lanes
  rv_isa_pkg::instr_t   instr_q;
  cb_pkg::tag_t         tag_q;

  assign idle  = ~busy;
  // Two's complement trick isolates the lowest set bit
  assign grant = idle & (~idle + 1'b1);

  // Free slot, free lane, no flush in progress
  assign in_ready = run_q & ~full & (|idle) & ~flush;

  // Every accepted instruction takes the tail slot
  assign alloc = in_valid & in_ready;

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      run_q     <= 1'b0;
      issue_vld <= '0;
    end else begin
      run_q <= 1'b1;
      // Valid lasts one cycle, lane holds its own copy
      if (alloc) begin
        issue_vld <= grant;
      end else begin
        issue_vld <= '0;
      end
    end
  end

  // Payload is captured only on acceptance
  always_ff @(posedge CLK) begin
    if (alloc) begin
      instr_q <= in_instr;
      // Zero-extend the slot index into the tag
      tag_q   <= cb_pkg::tag_t'(tail);
    end
  end

  // Fan the registered issue out to the lanes
  for (genvar g = 0; g < NUM_LANES; g++) begin : g_issue
    assign issue[g] = '{valid: issue_vld[g], instr: instr_q, tag: tag_q};

    // No back-to-back issue to one lane
    a_issue_idle: assert property (
      @(posedge CLK) disable iff (!nRST)
      issue_vld[g] |-> !$past(issue_vld[g])
    );
  end

  // Single issue per cycle
  a_issue_onehot: assert property (
    @(posedge CLK) disable iff (!nRST)
    $onehot0(issue_vld)
  );

endmodule

`default_nettype wire

// ==== src/exec_lane.sv ====
// Integer execution lane
`default_nettype none
`timescale 1ns/1ns

module exec_lane (
  input  logic            CLK,
  input  logic            nRST,
  input  cb_pkg::issue_t  issue,
  input  logic            flush,
  output logic            busy,
  output cb_pkg::result_t result
);

  cb_pkg::lane_state_t  state;
  rv_isa_pkg::word_t    alu_out;
  // Shift-add multiplier datapath
  rv_isa_pkg::word_t    mul_a;
  rv_isa_pkg::word_t    mul_b;
  rv_isa_pkg::word_t    acc;
  rv_isa_pkg::word_t    mul_step;
  logic                 mul_last;
  logic                 issue_wen;
  // Result register, only res_ready is control
  logic                 res_ready;
  cb_pkg::tag_t         res_tag;
  rv_isa_pkg::word_t    res_data;
  rv_isa_pkg::reg_idx_t res_rd;
  logic                 res_wen;
  logic                 res_exc;
  rv_isa_pkg::id_t      res_id;

  // Single-cycle operations
  always_comb begin
    case (issue.instr.op)
      rv_isa_pkg::OP_ADD: alu_out = issue.instr.a + issue.instr.b;
      rv_isa_pkg::OP_SUB: alu_out = issue.instr.a - issue.instr.b;
      rv_isa_pkg::OP_AND: alu_out = issue.instr.a & issue.instr.b;
      rv_isa_pkg::OP_XOR: alu_out = issue.instr.a ^ issue.instr.b;
      // Shift amount from b[4:0]
      rv_isa_pkg::OP_SLL: alu_out = issue.instr.a << issue.instr.b[4:0];
      default:            alu_out = '0;
    endcase
  end

  // No write for NOP, illegal or x0
  assign issue_wen = (issue.instr.op != rv_isa_pkg::OP_NOP) &&
                     (issue.instr.op != rv_isa_pkg::OP_ILLEGAL) &&
                     (issue.instr.rd != '0);

  // Partial product for this step; last when the remaining b runs out
  assign mul_step = acc + (mul_b[0] ? mul_a : '0);
  assign mul_last = (mul_b[31:1] == '0);

  assign busy = (state == cb_pkg::LANE_MUL) | issue.valid;

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      state     <= cb_pkg::LANE_IDLE;
      res_ready <= 1'b0;
    end else begin
      res_ready <= 1'b0;
      // Flush drops the issue in flight and any multiply
      if (flush) begin
        state <= cb_pkg::LANE_IDLE;
      end else if (state == cb_pkg::LANE_IDLE) begin
        if (issue.valid && issue.instr.op == rv_isa_pkg::OP_MUL) begin
          state <= cb_pkg::LANE_MUL;
        end else if (issue.valid) begin
          res_ready <= 1'b1;
        end
      end else if (mul_last) begin
        state     <= cb_pkg::LANE_IDLE;
        res_ready <= 1'b1;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (issue.valid) begin
      res_tag  <= issue.tag;
      res_rd   <= issue.instr.rd;
      res_wen  <= issue_wen;
      res_exc  <= (issue.instr.op == rv_isa_pkg::OP_ILLEGAL);
      res_id   <= issue.instr.id;
      res_data <= alu_out;
      // Multiplier operands, used only for OP_MUL
      mul_a    <= issue.instr.a;
      mul_b    <= issue.instr.b;
      acc      <= '0;
    end else if (state == cb_pkg::LANE_MUL) begin
      mul_a <= mul_a << 1;
      mul_b <= mul_b >> 1;
      acc   <= mul_step;
      // Product modulo 2^32
      if (mul_last) begin
        res_data <= mul_step;
      end
    end
  end

  assign result = '{ready: res_ready, tag: res_tag, data: res_data, rd: res_rd,
                    wen: res_wen, exception: res_exc, id: res_id};

  // Dispatch must not pick a lane that is multiplying
  a_no_issue_in_mul: assert property (
    @(posedge CLK) disable iff (!nRST)
    issue.valid |-> (state != cb_pkg::LANE_MUL)
  );

endmodule

`default_nettype wire

// ==== src/completion_buffer.sv ====
// In-order completion buffer
`default_nettype none
`timescale 1ns/1ns

module completion_buffer #(
  parameter int NUM_ENTRY = 8,
  parameter int NUM_LANES = 3
) (
  input  logic                         CLK,
  input  logic                         nRST,
  input  logic                         alloc,
  input  cb_pkg::result_t              result [NUM_LANES],
  output logic [$clog2(NUM_ENTRY)-1:0] tail,
  output logic                         full,
  output logic                         flush,
  output cb_pkg::commit_t              commit
);

  localparam int IDX_W = $clog2(NUM_ENTRY);

  // Entry payload, written by the lane that owns the slot
  typedef struct packed {
    rv_isa_pkg::word_t    data;
    rv_isa_pkg::reg_idx_t rd;
    logic                 wen;
    logic                 exception;
    rv_isa_pkg::id_t      id;
  } entry_t;

  entry_t               ent [NUM_ENTRY];
  // Result has arrived for this slot
  logic [NUM_ENTRY-1:0] done;

  // Extra MSB tells full from empty
  logic [IDX_W:0]       head_q;
  logic [IDX_W:0]       tail_q;
  logic [IDX_W-1:0]     head_sel;
  logic [IDX_W:0]       occupancy;
  logic                 move_head;

  assign head_sel  = head_q[IDX_W-1:0];
  assign tail      = tail_q[IDX_W-1:0];
  assign occupancy = tail_q - head_q;

  // Same index, different wrap bit
  assign full = (head_q[IDX_W-1:0] == tail_q[IDX_W-1:0]) &&
                (head_q[IDX_W] != tail_q[IDX_W]);

  // Finished excepting entry at the head flushes everything
  assign flush     = done[head_sel] & ent[head_sel].exception;
  assign move_head = done[head_sel] & ~flush;

  // Head entry drives commit, the flushing entry commits too
  assign commit = '{valid:     done[head_sel],
                    id:        ent[head_sel].id,
                    rd:        ent[head_sel].rd,
                    data:      ent[head_sel].data,
                    wen:       ent[head_sel].wen,
                    exception: ent[head_sel].exception};

  // Pointers and done flags
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      head_q <= '0;
      tail_q <= '0;
      done   <= '0;
    end else if (flush) begin
      // Younger entries are dropped
      head_q <= '0;
      tail_q <= '0;
      done   <= '0;
    end else begin
      if (move_head) begin
        head_q         <= head_q + 1'b1;
        done[head_sel] <= 1'b0;
      end
      if (alloc) begin
        tail_q <= tail_q + 1'b1;
      end
      // Writeback from every lane, slots never collide
      for (int l = 0; l < NUM_LANES; l++) begin
        if (result[l].ready) begin
          done[result[l].tag[IDX_W-1:0]] <= 1'b1;
        end
      end
    end
  end

  // Entry payload by tag
  always_ff @(posedge CLK) begin
    for (int l = 0; l < NUM_LANES; l++) begin
      if (result[l].ready) begin
        ent[result[l].tag[IDX_W-1:0]] <= '{data:      result[l].data,
                                           rd:        result[l].rd,
                                           wen:       result[l].wen,
                                           exception: result[l].exception,
                                           id:        result[l].id};
      end
    end
  end

  // Results only land in allocated slots
  for (genvar g = 0; g < NUM_LANES; g++) begin : g_chk
    // Distance of the tag from the head, modulo buffer size
    logic [IDX_W-1:0] offs;

    assign offs = result[g].tag[IDX_W-1:0] - head_sel;

    a_result_in_window: assert property (
      @(posedge CLK) disable iff (!nRST)
      result[g].ready |-> ({1'b0, offs} < occupancy)
    );
  end

  // Dispatch holds off while the buffer is full
  a_no_alloc_full: assert property (
    @(posedge CLK) disable iff (!nRST)
    alloc |-> !full
  );

endmodule

`default_nettype wire

// ==== src/ooo_backend_top.sv ====
// Out-of-order back end
`default_nettype none
`timescale 1ns/1ns

module ooo_backend_top #(
  parameter int NUM_ENTRY = 8,
  parameter int NUM_LANES = 3
) (
  input  logic               CLK,
  input  logic               nRST,
  input  rv_isa_pkg::instr_t in_instr,
  input  logic               in_valid,
  output logic               in_ready,
  output cb_pkg::commit_t    commit
);

  // Buffer to dispatch
  logic [$clog2(NUM_ENTRY)-1:0] tail;
  logic                         full;
  logic                         flush;
  logic                         alloc;

  // Dispatch and lanes
  logic [NUM_LANES-1:0]         busy;
  cb_pkg::issue_t               issue  [NUM_LANES];
  cb_pkg::result_t              result [NUM_LANES];

  dispatch_unit #(
    .NUM_ENTRY (NUM_ENTRY),
    .NUM_LANES (NUM_LANES)
  ) u_dispatch (
    .CLK      (CLK),
    .nRST     (nRST),
    .in_instr (in_instr),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .tail     (tail),
    .full     (full),
    .flush    (flush),
    .busy     (busy),
    .alloc    (alloc),
    .issue    (issue)
  );

  // Identical lanes, each writes back by tag
  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    exec_lane u_lane (
      .CLK    (CLK),
      .nRST   (nRST),
      .issue  (issue[i]),
      .flush  (flush),
      .busy   (busy[i]),
      .result (result[i])
    );
  end

  completion_buffer #(
    .NUM_ENTRY (NUM_ENTRY),
    .NUM_LANES (NUM_LANES)
  ) u_cb (
    .CLK    (CLK),
    .nRST   (nRST),
    .alloc  (alloc),
    .result (result),
    .tail   (tail),
    .full   (full),
    .flush  (flush),
    .commit (commit)
  );

endmodule

`default_nettype wire

// ==== test/tb_ooo_backend.sv ====
// Back-end testbench
`default_nettype none
`timescale 1ns/1ns

module tb_ooo_backend;

  localparam int NUM_ENTRY  = 8;
  localparam int NUM_LANES  = 3;
  // Cycles allowed for one handshake or one commit
  localparam int WAIT_LIMIT = 200;
  localparam int RUN_LIMIT  = 5000;

  logic               CLK;
  logic               nRST;
  rv_isa_pkg::instr_t in_instr;
  logic               in_valid;
  logic               in_ready;
  cb_pkg::commit_t    commit;

  // Instructions from the cases file, in program order
  rv_isa_pkg::instr_t cases_q [$];
  // Expected commits of accepted instructions
  cb_pkg::commit_t    exp_q [$];
  // Data is defined only for ALU and MUL opcodes
  logic               data_chk_q [$];
  logic [31:0]        lfsr;

  ooo_backend_top #(
    .NUM_ENTRY (NUM_ENTRY),
    .NUM_LANES (NUM_LANES)
  ) dut (
    .CLK      (CLK),
    .nRST     (nRST),
    .in_instr (in_instr),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .commit   (commit)
  );

  // 4 ns clock period
  always #2 CLK = ~CLK;

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // Result value by opcode
  function automatic logic [31:0] ref_data(input rv_isa_pkg::instr_t ins);
    case (ins.op)
      rv_isa_pkg::OP_ADD: return ins.a + ins.b;
      rv_isa_pkg::OP_SUB: return ins.a - ins.b;
      rv_isa_pkg::OP_AND: return ins.a & ins.b;
      rv_isa_pkg::OP_XOR: return ins.a ^ ins.b;
      // Shift amount is b[4:0]
      rv_isa_pkg::OP_SLL: return ins.a << ins.b[4:0];
      // Low 32 bits of the product
      rv_isa_pkg::OP_MUL: return ins.a * ins.b;
      default:            return 32'h0;
    endcase
  endfunction

  function automatic cb_pkg::commit_t ref_commit(input rv_isa_pkg::instr_t ins);
    cb_pkg::commit_t c;
    c.valid     = 1'b1;
    c.id        = ins.id;
    c.rd        = ins.rd;
    c.data      = ref_data(ins);
    // x0 is never written, nor are NOP and illegal
    c.wen       = (ins.op != rv_isa_pkg::OP_NOP) && (ins.op != rv_isa_pkg::OP_ILLEGAL) &&
                  (ins.rd != 5'd0);
    c.exception = (ins.op == rv_isa_pkg::OP_ILLEGAL);
    return c;
  endfunction

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("TB FAILED");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic read_cases();
    int                 fd;
    int                 n;
    string              line;
    logic [31:0]        f_op;
    logic [31:0]        f_rd;
    logic [31:0]        f_a;
    logic [31:0]        f_b;
    logic [31:0]        f_id;
    rv_isa_pkg::instr_t ins;
    fd = $fopen("test/ooo_cases.txt", "r");
    if (fd == 0) begin
      abort_run("Could not open the cases file test/ooo_cases.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n    = $fgets(line, fd);
        // Blank lines and lines starting with # carry no instruction
        if (n > 1 && line.getc(0) != 8'h23) begin
          n = $sscanf(line, "%h %h %h %h %h", f_op, f_rd, f_a, f_b, f_id);
          if (n != 5) begin
            abort_run($sformatf("Cases file line is malformed: %s", line));
          end else begin
            ins.op = rv_isa_pkg::opcode_t'(f_op[2:0]);
            ins.rd = f_rd[4:0];
            ins.a  = f_a;
            ins.b  = f_b;
            ins.id = f_id[7:0];
            cases_q.push_back(ins);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // Compare a commit against the oldest accepted instruction
  task automatic check_commit();
    cb_pkg::commit_t e;
    logic            dchk;
    if (commit.valid) begin
      if (exp_q.size() == 0) begin
        abort_run($sformatf("Unexpected commit of id %h at %0t ns with nothing outstanding",
                            commit.id, $time));
      end else begin
        e    = exp_q.pop_front();
        dchk = data_chk_q.pop_front();
        check_value(32'(commit.id), 32'(e.id), "commit id");
        check_value(32'(commit.rd), 32'(e.rd), $sformatf("rd of id %h", e.id));
        check_value(32'(commit.wen), 32'(e.wen), $sformatf("wen of id %h", e.id));
        check_value(32'(commit.exception), 32'(e.exception),
                    $sformatf("exception of id %h", e.id));
        if (dchk) begin
          check_value(commit.data, e.data, $sformatf("data of id %h", e.id));
        end
        // Flush drops every younger accepted instruction
        if (e.exception) begin
          exp_q.delete();
          data_chk_q.delete();
        end
      end
    end
  endtask

  initial begin
    int   pos;
    int   gap;
    int   stall;
    int   idle;
    int   cycles;
    logic took;
    CLK      = 1'b0;
    nRST     = 1'b0;
    in_valid = 1'b0;
    in_instr = '0;
    lfsr     = 32'h2226_8bf3;
    pos      = 0;
    gap      = 0;
    stall    = 0;
    idle     = 0;
    cycles   = 0;
    took     = 1'b0;
    read_cases();
    // Port stays closed and silent through reset
    repeat (16) begin
      @(negedge CLK);
      check_value(32'(in_ready), 32'd0, "in_ready in reset");
      check_value(32'(commit.valid), 32'd0, "commit valid in reset");
    end
    nRST = 1'b1;

    // One step per falling edge, inputs change only here
    while (pos < cases_q.size() || in_valid || exp_q.size() != 0) begin
      @(negedge CLK);
      cycles++;
      check_commit();
      // Empty buffer and idle lanes right after reset
      if (cycles == 1) begin
        check_value(32'(in_ready), 32'd1, "in_ready after reset");
      end
      // Transfer took place on the last rising edge
      if (in_valid && took) begin
        in_valid = 1'b0;
        lfsr     = lfsr_next(lfsr);
        gap      = int'(lfsr[0]);
        lfsr     = lfsr_next(lfsr);
        gap      = gap * 2 + int'(lfsr[0]);
      end
      if (!in_valid && gap > 0) begin
        gap--;
      end else if (!in_valid && pos < cases_q.size()) begin
        in_instr = cases_q[pos];
        in_valid = 1'b1;
        stall    = 0;
        pos++;
      end
      // in_ready is stable here and holds through the next rising edge
      took = 1'b0;
      if (in_valid) begin
        if (in_ready) begin
          took = 1'b1;
          exp_q.push_back(ref_commit(in_instr));
          data_chk_q.push_back((in_instr.op != rv_isa_pkg::OP_NOP) &&
                               (in_instr.op != rv_isa_pkg::OP_ILLEGAL));
        end else begin
          stall++;
        end
      end
      if (exp_q.size() != 0 && !commit.valid) begin
        idle++;
      end else begin
        idle = 0;
      end
      if (stall > WAIT_LIMIT) begin
        abort_run("Timed out waiting for in_ready");
      end else if (idle > WAIT_LIMIT) begin
        abort_run("Timed out waiting for a commit");
      end else if (cycles > RUN_LIMIT) begin
        abort_run("Run exceeded its cycle limit");
      end
    end

    // Dropped instructions must stay silent
    repeat (8) begin
      @(negedge CLK);
      check_commit();
    end

    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== test/ooo_cases.txt ====
# One instruction per line, hex columns: opcode rd a b id
# Opcodes 0 NOP, 1 ADD, 2 SUB, 3 AND, 4 XOR, 5 SLL, 6 MUL, 7 ILLEGAL
1 01 00000005 00000007 01
2 02 00000003 00000008 02
3 03 f0f0f0f0 ff00ff00 03
4 04 12345678 ffffffff 04
5 05 00000001 0000001f 05
5 06 80000001 00000024 06
6 07 00001234 00000005 07
0 08 00000011 00000022 08
1 00 00000001 00000001 09
6 09 00000007 00000000 0a
6 0a 00000003 80000000 10
1 0b 00000001 00000001 11
1 0c 00000002 00000002 12
1 0d 00000003 00000003 13
1 0e 00000004 00000004 14
1 0f 00000005 00000005 15
2 10 00000006 00000001 16
1 11 00000007 00000007 17
1 12 00000008 00000008 18
4 13 00000009 0000000f 19
1 14 0000000a 0000000a 1a
6 15 deadbeef c0000001 20
7 16 00000000 00000000 21
1 17 00000001 00000002 22
1 18 00000003 00000004 23
2 19 00000010 00000001 24
1 1a 00000100 00000200 30
6 1b 00000006 00000007 31
5 1c 0000000f 00000004 32
3 1d ffff0000 00ff00ff 33

// ==== sim.f ====
src/rv_isa_pkg.sv
src/cb_pkg.sv
src/dispatch_unit.sv
src/exec_lane.sv
src/completion_buffer.sv
src/ooo_backend_top.sv
test/tb_ooo_backend.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the back-end simulation with Verilator
set -u

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
TOP=tb_ooo_backend

verilator --binary --timing --assert -Wno-fatal -f sim.f \
  --top-module "$TOP" -Mdir "$OBJ_DIR"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ_DIR/V$TOP"
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation ended with status $status"
  exit $status
fi
exit 0
